// ==== all.f ====
+incdir+logic
logic/i2c_reg_pkg.sv
logic/i2c_bus_pkg.sv
logic/i2c_reg_file.sv
logic/i2c_byte_fifo.sv
logic/i2c_byte_engine.sv
logic/i2c_xfer_ctrl.sv
logic/i2c_master_top.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the I2C master testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_i2c_master -o tb_sim > compile.log 2>&1
if [ $? -ne 0 ]; then
    echo "Compilation failed, see compile.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== test/tb_i2c_master.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the I2C master: register traffic, a target model and checks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "i2c_params.svh"

module tb_i2c_master
    import i2c_reg_pkg::*;
;

    localparam int     NUM_RAND = 6;
    localparam int     NUM_XFERS = 4 + 2 * NUM_RAND;
    localparam longint WATCHDOG_NS = longint'(NUM_XFERS) * 100 * 36 * 5 * 40;

    logic                   ps_clk;
    logic                   rstn_i;
    logic                   reg_wr;
    logic                   reg_rd;
    logic [`REG_ADDR_W-1:0] reg_addr;
    logic [31:0]            reg_wdata;
    logic [31:0]            reg_rdata;
    wire                    scl_oen;
    wire                    sda_oen;
    wire                    slave_sda;
    wire                    scl_bus;
    wire                    sda_bus;
    logic [7:0]             slave_byte;
    wire  [7:0]             slave_addr;
    wire  [7:0]             slave_data;
    integer                 seed;
    int                     tx_cnt;
    int                     rx_cnt;

    assign scl_bus = scl_oen;              // Wired-AND with pullups.
    assign sda_bus = sda_oen & slave_sda;

    i2c_master_top i2c_master_top_inst (
        .ps_clk     (ps_clk),
        .rstn_i     (rstn_i),
        .reg_wr_i   (reg_wr),
        .reg_rd_i   (reg_rd),
        .reg_addr_i (reg_addr),
        .reg_wdata_i(reg_wdata),
        .reg_rdata_o(reg_rdata),
        .scl_i      (scl_bus),
        .sda_i      (sda_bus),
        .scl_oen_o  (scl_oen),
        .sda_oen_o  (sda_oen)
    );

    i2c_slave_model #(.ADDR(7'h2A)) slave_inst (
        .scl_i      (scl_bus),
        .sda_i      (sda_bus),
        .read_byte_i(slave_byte),
        .sda_o      (slave_sda),
        .addr_o     (slave_addr),
        .data_o     (slave_data)
    );

    initial begin
        ps_clk = 1'b0;
        forever #20 ps_clk = ~ps_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished.");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    function automatic status_t ref_status(int txc, int rxc, logic busy, logic ack);
        status_t s;
        s          = '0;
        s.rx_empty = (rxc == 0);
        s.rx_full  = (rxc == `FIFO_DEPTH);
        s.tx_empty = (txc == 0);
        s.tx_full  = (txc == `FIFO_DEPTH);
        s.busy     = busy;
        s.rx_ack   = ack;
        return s;
    endfunction

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        $display("TB FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_status(status_t got, status_t exp);
        if (got !== exp) report_mismatch("status", got, exp);
    endtask

    task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic reg_write(reg_addr_e addr, logic [31:0] data);
        @(negedge ps_clk);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge ps_clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(reg_addr_e addr, output logic [31:0] data);
        @(negedge ps_clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge ps_clk);
        reg_rd = 1'b0;
        data   = reg_rdata;  // Registered on the edge in between.
    endtask

    task automatic wait_idle();
        logic [31:0] w;
        do begin
            reg_read(STATUS, w);
        end while (w[4]);
    endtask

    task automatic push_tx(logic [7:0] b);
        reg_write(TX, 32'(b));
        if (tx_cnt < `FIFO_DEPTH) tx_cnt++;
    endtask

    task automatic write_xfer(logic [6:0] addr7, logic [7:0] data, logic acked);
        logic [31:0] w;
        push_tx({addr7, 1'b0});
        push_tx(data);
        reg_write(CONTROL, 32'h3);
        wait_idle();
        tx_cnt -= 2;
        reg_read(STATUS, w);
        check_status(w, ref_status(tx_cnt, rx_cnt, 1'b0, !acked));
        reg_read(CONTROL, w);
        check_word("control after write", w, 32'h2);  // Only core_en clears.
        check_byte("target address", slave_addr, {addr7, 1'b0});
        if (acked) check_byte("target data", slave_data, data);
    endtask

    task automatic read_to_fifo(logic [7:0] data);
        logic [31:0] w;
        slave_byte = data;
        push_tx({7'h2A, 1'b1});
        reg_write(CONTROL, 32'h1);
        wait_idle();
        tx_cnt -= 1;
        rx_cnt += 1;
        reg_read(STATUS, w);
        check_status(w, ref_status(tx_cnt, rx_cnt, 1'b0, 1'b0));
    endtask

    task automatic read_xfer(logic [7:0] data);
        logic [31:0] w;
        read_to_fifo(data);
        reg_read(RX, w);
        rx_cnt -= 1;
        check_byte("rx byte", w[7:0], data);
        reg_read(STATUS, w);
        check_status(w, ref_status(tx_cnt, rx_cnt, 1'b0, 1'b0));
    endtask

    initial begin
        logic [31:0] w;
        seed       = 32'h62ce_f190;
        rstn_i     = 1'b0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        slave_byte = 8'h00;
        tx_cnt     = 0;
        rx_cnt     = 0;
        repeat (5) @(posedge ps_clk);
        @(negedge ps_clk);
        rstn_i = 1'b1;

        reg_read(STATUS, w);
        check_status(w, ref_status(0, 0, 1'b0, 1'b0));
        reg_read(PARAM, w);
        check_word("param", w, {16'h0, 8'(`FIFO_DEPTH), 8'd8});
        reg_read(CONTROL, w);
        check_word("control after reset", w, 32'h0);

        reg_write(CLKDIV, 32'd3);
        write_xfer(7'h2A, 8'hA5, 1'b1);
        read_xfer(8'h3C);

        read_to_fifo(8'hC3);  // This byte stays in the RX FIFO until the soft reset.
        for (int i = 0; i < `FIFO_DEPTH + 1; i++) push_tx(8'(i));  // Last push is dropped.
        reg_read(STATUS, w);
        check_status(w, ref_status(tx_cnt, rx_cnt, 1'b0, 1'b0));
        reg_write(CONTROL, 32'h4);
        reg_write(CONTROL, 32'h0);
        tx_cnt = 0;
        rx_cnt = 0;
        reg_read(STATUS, w);
        check_status(w, ref_status(0, 0, 1'b0, 1'b0));

        write_xfer(7'h15, 8'h5A, 1'b0);

        for (int i = 0; i < NUM_RAND; i++) begin
            reg_write(CLKDIV, 32'(($random(seed) & 3) + 1));
            write_xfer(7'h2A, 8'($random(seed)), 1'b1);
            read_xfer(8'($random(seed)));
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/i2c_slave_model.sv ====
////////////////////////////////////////////////////////////////////////////
// Behavioral I2C target: captures the address and one data byte, answers reads.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h2A
) (
    input  wire logic       scl_i,
    input  wire logic       sda_i,
    input  wire logic [7:0] read_byte_i,
    output logic            sda_o,
    output logic [7:0]      addr_o,
    output logic [7:0]      data_o
);

    logic       prev_scl = 1'b1;
    logic       prev_sda = 1'b1;
    logic       active = 1'b0;
    logic       in_data = 1'b0;
    logic       selected = 1'b0;
    logic       is_read = 1'b0;
    logic [3:0] bit_cnt = 4'd0;
    logic [7:0] shift = 8'd0;

    initial begin
        sda_o  = 1'b1;
        addr_o = 8'd0;
        data_o = 8'd0;
    end

    always @(scl_i or sda_i) begin
        if (scl_i === 1'b1 && prev_scl === 1'b1 && sda_i !== prev_sda) begin
            if (sda_i === 1'b0) begin  // Start condition.
                active   = 1'b1;
                in_data  = 1'b0;
                selected = 1'b0;
                bit_cnt  = 4'd0;
                addr_o   = 8'd0;
                data_o   = 8'd0;
            end else begin
                active = 1'b0;  // Stop condition.
            end
            sda_o = 1'b1;
        end else if (active && scl_i === 1'b1 && prev_scl === 1'b0) begin
            if (bit_cnt < 4'd8) begin
                shift = {shift[6:0], sda_i};
            end
            bit_cnt = bit_cnt + 4'd1;
        end else if (active && scl_i === 1'b0 && prev_scl === 1'b1) begin
            if (bit_cnt == 4'd8) begin
                sda_o = 1'b1;
                if (!in_data) begin
                    addr_o   = shift;
                    selected = (shift[7:1] == ADDR);
                    is_read  = shift[0];
                    sda_o    = !selected;
                end else if (selected && !is_read) begin
                    data_o = shift;
                    sda_o  = 1'b0;
                end
            end else if (bit_cnt == 4'd9) begin
                sda_o   = 1'b1;
                bit_cnt = 4'd0;
                if (!in_data && selected && is_read) begin
                    sda_o = read_byte_i[7];  // First read bit goes out right after the ACK.
                end
                in_data = 1'b1;
            end else if (in_data && selected && is_read && bit_cnt > 4'd0) begin
                sda_o = read_byte_i[7 - bit_cnt];
            end
        end
        prev_scl = scl_i;
        prev_sda = sda_i;
    end

endmodule

`default_nettype wire

// ==== logic/i2c_master_top.sv ====
////////////////////////////////////////////////////////////////////////////
// I2C master top: register port, TX and RX FIFOs, sequencer and engine.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "i2c_params.svh"

module i2c_master_top
    import i2c_bus_pkg::*;
(
    input  wire logic                   ps_clk,
    input  wire logic                   rstn_i,
    input  wire logic                   reg_wr_i,
    input  wire logic                   reg_rd_i,
    input  wire logic [`REG_ADDR_W-1:0] reg_addr_i,
    input  wire logic [31:0]            reg_wdata_i,
    output logic      [31:0]            reg_rdata_o,
    input  wire logic                   scl_i,
    input  wire logic                   sda_i,
    output logic                        scl_oen_o,
    output logic                        sda_oen_o
);

    logic                   core_en;
    logic                   rw;
    logic                   soft_rst;
    logic [`PRESCALE_W-1:0] prescale;
    logic                   en_clear;
    bus_cmd_e               cmd;
    logic                   cmd_ack;
    logic                   busy;
    logic                   rx_ack;
    logic                   tx_push;
    logic                   tx_pop;
    logic [`I2C_DATA_W-1:0] tx_wdata;
    logic [`I2C_DATA_W-1:0] tx_head;
    logic                   tx_full;
    logic                   tx_empty;
    logic                   rx_push;
    logic                   rx_pop;
    logic [`I2C_DATA_W-1:0] rx_byte;
    logic [`I2C_DATA_W-1:0] rx_head;
    logic                   rx_full;
    logic                   rx_empty;

    i2c_reg_file i2c_reg_file_inst (
        .ps_clk     (ps_clk),
        .rstn_i     (rstn_i),
        .reg_wr_i   (reg_wr_i),
        .reg_rd_i   (reg_rd_i),
        .reg_addr_i (reg_addr_i),
        .reg_wdata_i(reg_wdata_i),
        .en_clear_i (en_clear),
        .tx_full_i  (tx_full),
        .tx_empty_i (tx_empty),
        .rx_full_i  (rx_full),
        .rx_empty_i (rx_empty),
        .rx_data_i  (rx_head),
        .busy_i     (busy),
        .rx_ack_i   (rx_ack),
        .reg_rdata_o(reg_rdata_o),
        .core_en_o  (core_en),
        .rw_o       (rw),
        .soft_rst_o (soft_rst),
        .prescale_o (prescale),
        .tx_push_o  (tx_push),
        .tx_data_o  (tx_wdata),
        .rx_pop_o   (rx_pop)
    );

    i2c_byte_fifo #(.DEPTH(`FIFO_DEPTH)) tx_fifo_inst (
        .ps_clk (ps_clk),
        .rstn_i (rstn_i),
        .clear_i(soft_rst),
        .push_i (tx_push),
        .pop_i  (tx_pop),
        .data_i (tx_wdata),
        .data_o (tx_head),
        .full_o (tx_full),
        .empty_o(tx_empty)
    );

    i2c_byte_fifo #(.DEPTH(`FIFO_DEPTH)) rx_fifo_inst (
        .ps_clk (ps_clk),
        .rstn_i (rstn_i),
        .clear_i(soft_rst),
        .push_i (rx_push),
        .pop_i  (rx_pop),
        .data_i (rx_byte),
        .data_o (rx_head),
        .full_o (rx_full),
        .empty_o(rx_empty)
    );

    i2c_xfer_ctrl i2c_xfer_ctrl_inst (
        .ps_clk    (ps_clk),
        .rstn_i    (rstn_i),
        .soft_rst_i(soft_rst),
        .core_en_i (core_en),
        .rw_i      (rw),
        .cmd_ack_i (cmd_ack),
        .cmd_o     (cmd),
        .tx_pop_o  (tx_pop),
        .en_clear_o(en_clear)
    );

    i2c_byte_engine i2c_byte_engine_inst (
        .ps_clk    (ps_clk),
        .rstn_i    (rstn_i),
        .soft_rst_i(soft_rst),
        .prescale_i(prescale),
        .cmd_i     (cmd),
        .tx_byte_i (tx_head),
        .scl_i     (scl_i),
        .sda_i     (sda_i),
        .cmd_ack_o (cmd_ack),
        .rx_byte_o (rx_byte),
        .rx_push_o (rx_push),
        .rx_ack_o  (rx_ack),
        .busy_o    (busy),
        .scl_oen_o (scl_oen_o),
        .sda_oen_o (sda_oen_o)
    );

endmodule

`default_nettype wire

// ==== logic/i2c_xfer_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Transfer sequencer: start, address byte, one data byte, stop.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module i2c_xfer_ctrl
    import i2c_bus_pkg::*;
(
    input  wire logic ps_clk,
    input  wire logic rstn_i,
    input  wire logic soft_rst_i,
    input  wire logic core_en_i,
    input  wire logic rw_i,
    input  wire logic cmd_ack_i,
    output bus_cmd_e  cmd_o,
    output logic      tx_pop_o,
    output logic      en_clear_o
);

    xfer_state_e state;

    always_ff @(posedge ps_clk) begin
        if (!rstn_i || soft_rst_i) begin
            state <= IDLE;
            cmd_o <= CMD_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (core_en_i) begin
                        state <= ADDR;
                        cmd_o <= CMD_START;
                    end
                end
                ADDR: begin
                    if (cmd_ack_i) begin
                        if (cmd_o == CMD_START) begin
                            cmd_o <= CMD_WRITE;  // Address byte follows the start.
                        end else begin
                            state <= DATA;
                            cmd_o <= rw_i ? CMD_WRITE : CMD_READ;
                        end
                    end
                end
                DATA: begin
                    if (cmd_ack_i) begin
                        state <= STOP;
                        cmd_o <= CMD_STOP;
                    end
                end
                STOP: begin
                    if (cmd_ack_i) begin
                        state <= IDLE;
                        cmd_o <= CMD_NONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Both pulses are combinational so core_en is low once IDLE is reached.
    assign tx_pop_o   = cmd_ack_i && (cmd_o == CMD_WRITE);
    assign en_clear_o = cmd_ack_i && (state == STOP);

    a_ack_has_cmd: assert property (@(posedge ps_clk) disable iff (!rstn_i || soft_rst_i)
        cmd_ack_i |-> cmd_o != CMD_NONE);

endmodule

`default_nettype wire

// ==== logic/i2c_byte_engine.sv ====
////////////////////////////////////////////////////////////////////////////
// I2C bit engine: runs start, byte write, byte read and stop on the
// open-drain pads, one quarter SCL period per prescale+1 cycles.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "i2c_params.svh"

module i2c_byte_engine
    import i2c_bus_pkg::*;
(
    input  wire logic                   ps_clk,
    input  wire logic                   rstn_i,
    input  wire logic                   soft_rst_i,
    input  wire logic [`PRESCALE_W-1:0] prescale_i,
    input  wire bus_cmd_e               cmd_i,
    input  wire logic [`I2C_DATA_W-1:0] tx_byte_i,
    input  wire logic                   scl_i,
    input  wire logic                   sda_i,
    output logic                        cmd_ack_o,
    output logic      [`I2C_DATA_W-1:0] rx_byte_o,
    output logic                        rx_push_o,
    output logic                        rx_ack_o,
    output logic                        busy_o,
    output logic                        scl_oen_o,
    output logic                        sda_oen_o
);

    localparam int BW = $clog2(`I2C_DATA_W + 1);

    bus_cmd_e               cur_cmd;
    logic                   active;
    logic [`PRESCALE_W-1:0] cnt;
    logic [1:0]             qtr;
    logic [BW-1:0]          bit_cnt;
    logic [BW-1:0]          nxt_bit;
    logic [`I2C_DATA_W-1:0] sr;
    logic [1:0]             scl_sync;
    logic [1:0]             sda_sync;
    logic                   bus_free;
    logic                   accept;
    logic                   tick;
    logic                   last_qtr;
    logic                   is_byte;

    // Pad enables for one quarter, returned as {scl_oen, sda_oen}.
    function automatic logic [1:0] pad_oen(bus_cmd_e cmd, logic [BW-1:0] bit_idx,
                                           logic [1:0] q, logic msb);
        logic scl_hi;
        scl_hi = (q == 2'd1) || (q == 2'd2);
        case (cmd)
            CMD_START: return {q != 2'd3, q < 2'd2};     // SDA falls while SCL is high.
            CMD_STOP:  return {q != 2'd0, q == 2'd3};    // SDA rises while SCL is high.
            CMD_WRITE: return {scl_hi, (bit_idx == BW'(`I2C_DATA_W)) ? 1'b1 : msb};
            default:   return {scl_hi, 1'b1};           // Read bits and the NACK release SDA.
        endcase
    endfunction

    assign bus_free = scl_sync[1] && sda_sync[1];
    assign accept   = !active && !cmd_ack_o && (cmd_i != CMD_NONE) &&
                      ((cmd_i != CMD_START) || bus_free);
    assign tick     = active && (cnt == prescale_i);
    assign is_byte  = (cur_cmd == CMD_WRITE) || (cur_cmd == CMD_READ);
    assign last_qtr = (qtr == 2'd3) && (!is_byte || (bit_cnt == BW'(`I2C_DATA_W)));
    assign nxt_bit  = (qtr == 2'd3) ? bit_cnt + 1'b1 : bit_cnt;
    assign rx_byte_o = sr;

    always_ff @(posedge ps_clk) begin
        if (!rstn_i) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
        end else begin
            scl_sync <= {scl_sync[0], scl_i};
            sda_sync <= {sda_sync[0], sda_i};
        end
    end

    always_ff @(posedge ps_clk) begin
        if (!rstn_i || soft_rst_i) begin
            active    <= 1'b0;
            cur_cmd   <= CMD_NONE;
            cnt       <= '0;
            qtr       <= '0;
            bit_cnt   <= '0;
            cmd_ack_o <= 1'b0;
            rx_push_o <= 1'b0;
            rx_ack_o  <= 1'b0;
            busy_o    <= 1'b0;
            scl_oen_o <= 1'b1;
            sda_oen_o <= 1'b1;
        end else begin
            cmd_ack_o <= 1'b0;
            rx_push_o <= 1'b0;
            if (accept) begin
                active  <= 1'b1;
                cur_cmd <= cmd_i;
                cnt     <= '0;
                qtr     <= '0;
                bit_cnt <= '0;
                if (cmd_i == CMD_START) begin
                    busy_o <= 1'b1;
                end
                {scl_oen_o, sda_oen_o} <= pad_oen(cmd_i, '0, 2'd0, tx_byte_i[`I2C_DATA_W-1]);
            end else if (tick) begin
                cnt <= '0;
                if (qtr == 2'd2 && cur_cmd == CMD_WRITE && bit_cnt == BW'(`I2C_DATA_W)) begin
                    rx_ack_o <= sda_sync[1];  // Low means the target acknowledged.
                end
                if (last_qtr) begin
                    active    <= 1'b0;
                    cmd_ack_o <= 1'b1;
                    rx_push_o <= (cur_cmd == CMD_READ);
                    if (cur_cmd == CMD_STOP) begin
                        busy_o <= 1'b0;
                    end
                end else begin
                    qtr     <= qtr + 1'b1;
                    bit_cnt <= nxt_bit;
                    {scl_oen_o, sda_oen_o} <= pad_oen(cur_cmd, nxt_bit, qtr + 1'b1,
                                                      sr[`I2C_DATA_W-1]);
                end
            end else if (active) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Bits move at the end of the SCL high time, MSB first.
    always_ff @(posedge ps_clk) begin
        if (accept && cmd_i == CMD_WRITE) begin
            sr <= tx_byte_i;
        end else if (tick && is_byte && qtr == 2'd2 && bit_cnt < BW'(`I2C_DATA_W)) begin
            sr <= {sr[`I2C_DATA_W-2:0], sda_sync[1]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2c_byte_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// Synchronous byte FIFO with full and empty flags and a soft clear.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "i2c_params.svh"

module i2c_byte_fifo #(
    parameter int DEPTH = 8
) (
    input  wire logic                   ps_clk,
    input  wire logic                   rstn_i,
    input  wire logic                   clear_i,
    input  wire logic                   push_i,
    input  wire logic                   pop_i,
    input  wire logic [`I2C_DATA_W-1:0] data_i,
    output logic      [`I2C_DATA_W-1:0] data_o,
    output logic                        full_o,
    output logic                        empty_o
);

    localparam int AW = $clog2(DEPTH);

    logic [`I2C_DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [AW:0]            count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count == (AW + 1)'(DEPTH));
    assign empty_o = (count == '0);
    assign data_o  = mem[rd_ptr];  // Head is always visible.

    always_ff @(posedge ps_clk) begin
        if (!rstn_i || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
        end
    end

    always_ff @(posedge ps_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    a_no_overflow: assert property (@(posedge ps_clk) disable iff (!rstn_i)
        !(push_i && full_o));
    a_no_underflow: assert property (@(posedge ps_clk) disable iff (!rstn_i)
        !(pop_i && empty_o));

endmodule

`default_nettype wire

// ==== logic/i2c_reg_file.sv ====
////////////////////////////////////////////////////////////////////////////
// I2C register file: address decode, control and clock registers,
// FIFO strobes and a registered read-back mux.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "i2c_params.svh"

module i2c_reg_file
    import i2c_reg_pkg::*;
(
    input  wire logic                   ps_clk,
    input  wire logic                   rstn_i,
    input  wire logic                   reg_wr_i,
    input  wire logic                   reg_rd_i,
    input  wire logic [`REG_ADDR_W-1:0] reg_addr_i,
    input  wire logic [31:0]            reg_wdata_i,
    input  wire logic                   en_clear_i,
    input  wire logic                   tx_full_i,
    input  wire logic                   tx_empty_i,
    input  wire logic                   rx_full_i,
    input  wire logic                   rx_empty_i,
    input  wire logic [`I2C_DATA_W-1:0] rx_data_i,
    input  wire logic                   busy_i,
    input  wire logic                   rx_ack_i,
    output logic      [31:0]            reg_rdata_o,
    output logic                        core_en_o,
    output logic                        rw_o,
    output logic                        soft_rst_o,
    output logic      [`PRESCALE_W-1:0] prescale_o,
    output logic                        tx_push_o,
    output logic      [`I2C_DATA_W-1:0] tx_data_o,
    output logic                        rx_pop_o
);

    reg_addr_e addr;
    reg_word_u wword;
    logic      ctrl_wr;
    control_t  ctrl_rd;
    clkdiv_t   clkdiv_rd;
    status_t   status;
    param_t    param;

    assign addr  = reg_addr_e'(reg_addr_i);
    assign wword = reg_wdata_i;

    assign ctrl_wr   = reg_wr_i && (addr == CONTROL);
    assign tx_push_o = reg_wr_i && (addr == TX) && !tx_full_i;  // A push on full is dropped.
    assign tx_data_o = reg_wdata_i[`I2C_DATA_W-1:0];
    assign rx_pop_o  = reg_rd_i && (addr == RX) && !rx_empty_i;

    always_ff @(posedge ps_clk) begin
        if (!rstn_i) begin
            core_en_o  <= 1'b0;
            rw_o       <= 1'b0;
            soft_rst_o <= 1'b0;
            prescale_o <= '0;
        end else begin
            if (ctrl_wr) begin
                core_en_o  <= wword.control.core_en;
                rw_o       <= wword.control.rw;
                soft_rst_o <= wword.control.core_rst;
            end else if (en_clear_i) begin
                core_en_o <= 1'b0;
            end
            if (reg_wr_i && (addr == CLKDIV)) begin
                prescale_o <= wword.clkdiv.prescale;
            end
        end
    end

    always_comb begin
        ctrl_rd          = '0;
        ctrl_rd.core_en  = core_en_o;
        ctrl_rd.rw       = rw_o;
        ctrl_rd.core_rst = soft_rst_o;

        clkdiv_rd          = '0;
        clkdiv_rd.prescale = prescale_o;

        status          = '0;
        status.rx_empty = rx_empty_i;
        status.rx_full  = rx_full_i;
        status.tx_empty = tx_empty_i;
        status.tx_full  = tx_full_i;
        status.busy     = busy_i || core_en_o;  // Covers the cycles before START begins.
        status.rx_ack   = rx_ack_i;

        param            = '0;
        param.data_width = 8'(`I2C_DATA_W);
        param.fifo_depth = 8'(`FIFO_DEPTH);
    end

    always_ff @(posedge ps_clk) begin
        if (reg_rd_i) begin
            case (addr)
                CONTROL: reg_rdata_o <= ctrl_rd;
                CLKDIV:  reg_rdata_o <= clkdiv_rd;
                RX:      reg_rdata_o <= 32'(rx_data_i);
                STATUS:  reg_rdata_o <= status;
                PARAM:   reg_rdata_o <= param;
                default: reg_rdata_o <= '0;
            endcase
        end
    end

    // A control write in the same cycle as the end of a transfer keeps its value.
    a_ctrl_write_wins: assert property (@(posedge ps_clk) disable iff (!rstn_i)
        ctrl_wr && en_clear_i |=> core_en_o == $past(wword.control.core_en));

endmodule

`default_nettype wire

// ==== logic/i2c_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// I2C bus engine commands and transfer sequencing states.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package i2c_bus_pkg;

    // Commands carry a prefix since STOP is also a transfer state.
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_START = 3'd1,
        CMD_WRITE = 3'd2,
        CMD_READ  = 3'd3,
        CMD_STOP  = 3'd4
    } bus_cmd_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        STOP = 2'd3
    } xfer_state_e;

endpackage

`default_nettype wire

// ==== logic/i2c_reg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// I2C register map: addresses, register layouts and the write-word view.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "i2c_params.svh"

package i2c_reg_pkg;

    typedef enum logic [`REG_ADDR_W-1:0] {
        CONTROL = 3'd0,
        CLKDIV  = 3'd1,
        TX      = 3'd2,
        RX      = 3'd3,
        STATUS  = 3'd4,
        PARAM   = 3'd5
    } reg_addr_e;

    typedef struct packed {
        logic [28:0] reserved;
        logic        core_rst;  // Holds the FIFOs and the bus engine in reset.
        logic        rw;        // 1 writes the data byte, 0 reads it.
        logic        core_en;
    } control_t;

    typedef struct packed {
        logic [31-`PRESCALE_W:0] reserved;
        logic [`PRESCALE_W-1:0]  prescale;
    } clkdiv_t;

    typedef union packed {
        control_t control;
        clkdiv_t  clkdiv;
    } reg_word_u;

    typedef struct packed {
        logic [25:0] reserved;
        logic        rx_ack;
        logic        busy;
        logic        tx_full;
        logic        tx_empty;
        logic        rx_full;
        logic        rx_empty;
    } status_t;

    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  fifo_depth;
        logic [7:0]  data_width;
    } param_t;

endpackage

`default_nettype wire

// ==== logic/i2c_params.svh ====
////////////////////////////////////////////////////////////////////////////
// I2C controller sizing: data width, FIFO depth, register address width
// and prescale counter width.
////////////////////////////////////////////////////////////////////////////

`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// Bits per transferred byte.
`define I2C_DATA_W 8

`define FIFO_DEPTH 8

// Register port address width.
`define REG_ADDR_W 3

`define PRESCALE_W 16

`endif
